// ==== src/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Width of one write lane in the LUT RAMs.
`define BYTE_LEN_IN_BITS 8

// One cache line is a single 64-bit word.
`define CACHE_LINE_BITS 64

// Direct mapped, so one line per set.
`define CACHE_NUM_SET 64
`define CACHE_SET_BITS 6

// The line address splits into tag and set index.
`define CACHE_TAG_BITS 8
`define CACHE_ADDR_BITS 14

// Requests that can wait in front of the lookup engine.
`define CACHE_QUEUE_DEPTH 4

`endif

// ==== src/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

    // Tag sits in the upper bits, set index in the lower bits.
    typedef struct packed
    {
        logic [`CACHE_TAG_BITS - 1 : 0] tag;
        logic [`CACHE_SET_BITS - 1 : 0] set;
    } cache_addr_fields_t;

    // The queue and the ports only move the raw word around.
    // The lookup engine reads it through the field view.
    typedef union packed
    {
        logic [`CACHE_ADDR_BITS - 1 : 0] raw;
        cache_addr_fields_t              fields;
    } cache_addr_u;

endpackage

// ==== src/single_port_lutram.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module single_port_lutram
#(
    parameter SINGLE_ENTRY_WIDTH_IN_BITS = `CACHE_LINE_BITS,
    parameter NUM_SET                    = `CACHE_NUM_SET,
    parameter SET_PTR_WIDTH_IN_BITS      = $clog2(NUM_SET),
    parameter WRITE_MASK_LEN             = SINGLE_ENTRY_WIDTH_IN_BITS / `BYTE_LEN_IN_BITS,
    parameter WITH_VALID_REG_ARRAY       = "Yes"
)
(
    input  logic                                      clk_in,
    input  logic                                      reset_in,

    input  logic                                      access_en_in,
    input  logic [WRITE_MASK_LEN - 1 : 0]             write_en_in,
    input  logic [SET_PTR_WIDTH_IN_BITS - 1 : 0]      access_set_addr_in,

    input  logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] write_entry_in,
    output logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] read_entry_out,
    output logic                                      read_valid_out
);

    logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] lut_ram [NUM_SET];

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : g_valid
            logic [NUM_SET - 1 : 0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array    <= '0;
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    // Any write lane marks the set as holding data.
                    if (access_en_in && |write_en_in)
                    begin
                        valid_array[access_set_addr_in] <= 1'b1;
                    end
                    read_valid_out <= access_en_in & valid_array[access_set_addr_in];
                end
            end
        end
        else
        begin : g_no_valid
            // Without the array, every access reads back valid data.
            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    read_valid_out <= access_en_in;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk_in)
    begin
        for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
        begin
            if (access_en_in && write_en_in[lane])
            begin
                lut_ram[access_set_addr_in][lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                    <= write_entry_in[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            end
        end
    end

    assign read_entry_out = lut_ram[access_set_addr_in];

endmodule

// ==== src/request_queue.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module request_queue
#(
    parameter int DEPTH = `CACHE_QUEUE_DEPTH
)
(
    input  logic                                              clk_in,
    input  logic                                              reset_in,

    input  logic                                              in_valid,
    output logic                                              in_ready,
    input  logic                                              in_write,
    input  cache_pkg::cache_addr_u                            in_addr,
    input  logic [`CACHE_LINE_BITS / `BYTE_LEN_IN_BITS - 1 : 0] in_byte_en,
    input  logic [`CACHE_LINE_BITS - 1 : 0]                   in_wdata,

    output logic                                              out_valid,
    input  logic                                              out_ready,
    output logic                                              out_write,
    output cache_pkg::cache_addr_u                            out_addr,
    output logic [`CACHE_LINE_BITS / `BYTE_LEN_IN_BITS - 1 : 0] out_byte_en,
    output logic [`CACHE_LINE_BITS - 1 : 0]                   out_wdata
);

    import cache_pkg::*;

    localparam int MASK_LEN = `CACHE_LINE_BITS / `BYTE_LEN_IN_BITS;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic                            write_mem   [DEPTH];
    cache_addr_u                     addr_mem    [DEPTH];
    logic [MASK_LEN - 1 : 0]         byte_en_mem [DEPTH];
    logic [`CACHE_LINE_BITS - 1 : 0] wdata_mem   [DEPTH];

    logic [PTR_BITS - 1 : 0] wr_ptr;
    logic [PTR_BITS - 1 : 0] rd_ptr;
    logic [CNT_BITS - 1 : 0] count;
    logic                    push;
    logic                    pop;

    // A full queue still takes a new entry when the head leaves in the same cycle.
    assign out_valid = (count != '0);
    assign in_ready  = (count != CNT_BITS'(DEPTH)) | out_ready;
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            write_mem[wr_ptr]   <= in_write;
            addr_mem[wr_ptr]    <= in_addr;
            byte_en_mem[wr_ptr] <= in_byte_en;
            wdata_mem[wr_ptr]   <= in_wdata;
        end
    end

    assign out_write   = write_mem[rd_ptr];
    assign out_addr    = addr_mem[rd_ptr];
    assign out_byte_en = byte_en_mem[rd_ptr];
    assign out_wdata   = wdata_mem[rd_ptr];

endmodule

// ==== src/cache_lookup.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_lookup
(
    input  logic                                              clk_in,
    input  logic                                              reset_in,

    input  logic                                              q_valid,
    output logic                                              q_ready,
    input  logic                                              q_write,
    input  cache_pkg::cache_addr_u                            q_addr,
    input  logic [`CACHE_LINE_BITS / `BYTE_LEN_IN_BITS - 1 : 0] q_byte_en,
    input  logic [`CACHE_LINE_BITS - 1 : 0]                   q_wdata,

    output logic                                              rsp_valid,
    input  logic                                              rsp_ready,
    output logic                                              rsp_write,
    output logic                                              rsp_hit,
    output logic [`CACHE_LINE_BITS - 1 : 0]                   rsp_rdata
);

    import cache_pkg::*;

    localparam int MASK_LEN = `CACHE_LINE_BITS / `BYTE_LEN_IN_BITS;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_PROBE = 2'd1;
    localparam logic [1:0] ST_OUT   = 2'd2;

    logic [1:0] state;

    // Request and RAM read captured on the queue handshake.
    logic                            req_write_r;
    cache_addr_u                     req_addr_r;
    logic [MASK_LEN - 1 : 0]         req_byte_en_r;
    logic [`CACHE_LINE_BITS - 1 : 0] req_wdata_r;
    logic [`CACHE_TAG_BITS - 1 : 0]  tag_r;
    logic [`CACHE_LINE_BITS - 1 : 0] line_r;

    logic                            q_fire;
    logic                            probe_write;
    logic                            ram_access;
    logic [`CACHE_SET_BITS - 1 : 0]  ram_set;
    logic [`CACHE_TAG_BITS - 1 : 0]  tag_rd;
    logic                            tag_rd_valid;
    logic [0:0]                      tag_we;
    logic [`CACHE_LINE_BITS - 1 : 0] line_rd;
    logic [MASK_LEN - 1 : 0]         data_we;
    logic                            hit;
    logic [`CACHE_LINE_BITS - 1 : 0] merged_line;

    assign q_ready     = (state == ST_IDLE);
    assign rsp_valid   = (state == ST_OUT);
    assign q_fire      = q_valid & q_ready;
    assign probe_write = (state == ST_PROBE) & req_write_r;
    assign ram_access  = q_fire | probe_write;
    assign ram_set     = (state == ST_PROBE) ? req_addr_r.fields.set : q_addr.fields.set;

    // A miss rewrites the whole line, so every lane is enabled.
    assign data_we   = probe_write ? (hit ? req_byte_en_r : '1) : '0;
    assign tag_we[0] = probe_write & ~hit;

    always_comb
    begin
        hit = tag_rd_valid & (tag_r == req_addr_r.fields.tag);
        for (int lane = 0; lane < MASK_LEN; lane++)
        begin
            if (req_byte_en_r[lane])
                merged_line[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                    = req_wdata_r[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            else if (hit)
                merged_line[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS]
                    = line_r[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS];
            else
                merged_line[lane * `BYTE_LEN_IN_BITS +: `BYTE_LEN_IN_BITS] = '0;
        end
    end

    single_port_lutram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (`CACHE_TAG_BITS),
        .NUM_SET                    (`CACHE_NUM_SET),
        .SET_PTR_WIDTH_IN_BITS      (`CACHE_SET_BITS),
        .WRITE_MASK_LEN             (1),
        .WITH_VALID_REG_ARRAY       ("Yes")
    )
    u_tag_ram
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en_in       (ram_access),
        .write_en_in        (tag_we),
        .access_set_addr_in (ram_set),
        .write_entry_in     (req_addr_r.fields.tag),
        .read_entry_out     (tag_rd),
        .read_valid_out     (tag_rd_valid)
    );

    single_port_lutram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (`CACHE_LINE_BITS),
        .NUM_SET                    (`CACHE_NUM_SET),
        .SET_PTR_WIDTH_IN_BITS      (`CACHE_SET_BITS),
        .WRITE_MASK_LEN             (MASK_LEN),
        .WITH_VALID_REG_ARRAY       ("No")
    )
    u_data_ram
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en_in       (ram_access),
        .write_en_in        (data_we),
        .access_set_addr_in (ram_set),
        .write_entry_in     (merged_line),
        .read_entry_out     (line_rd),
        .read_valid_out     ()
    );

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (q_fire)
                        state <= ST_PROBE;
                end
                ST_PROBE:
                begin
                    state <= ST_OUT;
                end
                ST_OUT:
                begin
                    if (rsp_ready)
                        state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (q_fire)
        begin
            req_write_r   <= q_write;
            req_addr_r    <= q_addr;
            req_byte_en_r <= q_byte_en;
            req_wdata_r   <= q_wdata;
            tag_r         <= tag_rd;
            line_r        <= line_rd;
        end
        // Writes and misses answer with zero data.
        if (state == ST_PROBE)
        begin
            rsp_write <= req_write_r;
            rsp_hit   <= hit;
            rsp_rdata <= (!req_write_r && hit) ? line_r : '0;
        end
    end

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top
(
    input  logic                                              clk_in,
    input  logic                                              reset_in,

    input  logic                                              req_valid,
    output logic                                              req_ready,
    input  logic                                              req_write,
    input  cache_pkg::cache_addr_u                            req_addr,
    input  logic [`CACHE_LINE_BITS / `BYTE_LEN_IN_BITS - 1 : 0] req_byte_en,
    input  logic [`CACHE_LINE_BITS - 1 : 0]                   req_wdata,

    output logic                                              rsp_valid,
    input  logic                                              rsp_ready,
    output logic                                              rsp_write,
    output logic                                              rsp_hit,
    output logic [`CACHE_LINE_BITS - 1 : 0]                   rsp_rdata
);

    import cache_pkg::*;

    logic                                               q_valid;
    logic                                               q_ready;
    logic                                               q_write;
    cache_addr_u                                        q_addr;
    logic [`CACHE_LINE_BITS / `BYTE_LEN_IN_BITS - 1 : 0] q_byte_en;
    logic [`CACHE_LINE_BITS - 1 : 0]                    q_wdata;

    request_queue
    #(
        .DEPTH (`CACHE_QUEUE_DEPTH)
    )
    u_queue
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .in_valid    (req_valid),
        .in_ready    (req_ready),
        .in_write    (req_write),
        .in_addr     (req_addr),
        .in_byte_en  (req_byte_en),
        .in_wdata    (req_wdata),
        .out_valid   (q_valid),
        .out_ready   (q_ready),
        .out_write   (q_write),
        .out_addr    (q_addr),
        .out_byte_en (q_byte_en),
        .out_wdata   (q_wdata)
    );

    cache_lookup u_lookup
    (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_write   (q_write),
        .q_addr    (q_addr),
        .q_byte_en (q_byte_en),
        .q_wdata   (q_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_write (rsp_write),
        .rsp_hit   (rsp_hit),
        .rsp_rdata (rsp_rdata)
    );

endmodule

// ==== tb/cache_checker.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_checker
(
    input logic                            clk_in,
    input logic                            reset_in,
    input logic                            req_valid,
    input logic                            req_ready,
    input logic                            q_valid,
    input logic                            q_ready,
    input logic                            rsp_valid,
    input logic                            rsp_ready,
    input logic                            rsp_write,
    input logic                            rsp_hit,
    input logic [`CACHE_LINE_BITS - 1 : 0] rsp_rdata
);

    logic [3:0] occupancy;

    // Requests taken at the port and not yet handed to the lookup engine.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            occupancy <= '0;
        end
        else
        begin
            occupancy <= occupancy + 4'(req_valid && req_ready) - 4'(q_valid && q_ready);
        end
    end

    // A stalled response must not change under the consumer.
    a_rsp_stable : assert property (@(posedge clk_in) disable iff (reset_in)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_write) && $stable(rsp_hit)
                                    && $stable(rsp_rdata))
        else $error("response changed while stalled");

    // Back-pressure only appears once the queue is full.
    a_ready_unless_full : assert property (@(posedge clk_in) disable iff (reset_in)
        occupancy != 4'(`CACHE_QUEUE_DEPTH) |-> req_ready)
        else $error("req_ready low while the queue has room");

    a_q_valid_when_held : assert property (@(posedge clk_in) disable iff (reset_in)
        q_valid == (occupancy != '0))
        else $error("q_valid does not match the queue occupancy");

    a_no_rsp_in_reset : assert property (@(posedge clk_in) reset_in |-> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule

bind cache_top cache_checker u_checker
(
    .clk_in    (clk_in),
    .reset_in  (reset_in),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .q_valid   (q_valid),
    .q_ready   (q_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_write (rsp_write),
    .rsp_hit   (rsp_hit),
    .rsp_rdata (rsp_rdata)
);

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int MASK_LEN   = `CACHE_LINE_BITS / `BYTE_LEN_IN_BITS;
    localparam int WAIT_LIMIT = 400;

    logic                            clk_in;
    logic                            reset_in;
    logic                            req_valid;
    logic                            req_ready;
    logic                            req_write;
    cache_addr_u                     req_addr;
    logic [MASK_LEN - 1 : 0]         req_byte_en;
    logic [`CACHE_LINE_BITS - 1 : 0] req_wdata;
    logic                            rsp_valid;
    logic                            rsp_ready;
    logic                            rsp_write;
    logic                            rsp_hit;
    logic [`CACHE_LINE_BITS - 1 : 0] rsp_rdata;

    // Request table, one entry per request, applied in order.
    logic                             tbl_write [$];
    logic [`CACHE_ADDR_BITS - 1 : 0]  tbl_addr  [$];
    logic [MASK_LEN - 1 : 0]          tbl_mask  [$];
    logic [`CACHE_LINE_BITS - 1 : 0]  tbl_data  [$];
    int                               tbl_stall [$];

    // Responses still owed by the DUT, oldest first.
    logic                             exp_write [$];
    logic                             exp_hit   [$];
    logic [`CACHE_LINE_BITS - 1 : 0]  exp_rdata [$];
    int                               exp_stall [$];

    // Reference cache contents per set.
    logic                             model_valid [`CACHE_NUM_SET];
    logic [`CACHE_TAG_BITS - 1 : 0]   model_tag   [`CACHE_NUM_SET];
    logic [`CACHE_LINE_BITS - 1 : 0]  model_line  [`CACHE_NUM_SET];

    logic ready_fell;

    cache_top u_dut
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_byte_en (req_byte_en),
        .req_wdata   (req_wdata),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_write   (rsp_write),
        .rsp_hit     (rsp_hit),
        .rsp_rdata   (rsp_rdata)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic fail_and_stop();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            fail_and_stop();
        end
    endtask

    function automatic logic [`CACHE_ADDR_BITS - 1 : 0] make_addr(
        input logic [`CACHE_TAG_BITS - 1 : 0] tag,
        input logic [`CACHE_SET_BITS - 1 : 0] set);
        return {tag, set};
    endfunction

    task automatic add_request(input logic wr, input logic [`CACHE_ADDR_BITS - 1 : 0] addr,
                               input logic [MASK_LEN - 1 : 0] mask,
                               input logic [`CACHE_LINE_BITS - 1 : 0] data, input int stall);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_mask.push_back(mask);
        tbl_data.push_back(data);
        tbl_stall.push_back(stall);
    endtask

    // A miss on a write starts from an empty line, then the enabled bytes land on top.
    task automatic apply_model(input logic wr, input logic [`CACHE_ADDR_BITS - 1 : 0] addr,
                               input logic [MASK_LEN - 1 : 0] mask,
                               input logic [`CACHE_LINE_BITS - 1 : 0] data,
                               output logic hit, output logic [`CACHE_LINE_BITS - 1 : 0] rdata);
        logic [`CACHE_SET_BITS - 1 : 0] set_idx;
        logic [`CACHE_TAG_BITS - 1 : 0] tag_val;
        set_idx = addr[`CACHE_SET_BITS - 1 : 0];
        tag_val = addr[`CACHE_ADDR_BITS - 1 : `CACHE_SET_BITS];
        hit     = model_valid[set_idx] && (model_tag[set_idx] == tag_val);
        rdata   = '0;
        if (!wr)
        begin
            if (hit)
                rdata = model_line[set_idx];
        end
        else
        begin
            if (!hit)
            begin
                model_valid[set_idx] = 1'b1;
                model_tag[set_idx]   = tag_val;
                model_line[set_idx]  = '0;
            end
            for (int lane = 0; lane < MASK_LEN; lane++)
            begin
                if (mask[lane])
                    model_line[set_idx][lane * 8 +: 8] = data[lane * 8 +: 8];
            end
        end
    endtask

    task automatic build_table();
        // Cold reads, all of them should miss.
        add_request(1'b0, make_addr(8'h00, 6'd0), 8'hFF, 64'h0, 0);
        add_request(1'b0, make_addr(8'h5A, 6'd17), 8'hFF, 64'h0, 0);
        add_request(1'b0, make_addr(8'hFF, 6'd63), 8'h00, 64'h0, 1);
        // Fill set 3, merge into it, then replace it with another tag.
        add_request(1'b1, make_addr(8'h12, 6'd3), 8'hFF, 64'h0123_4567_89AB_CDEF, 0);
        add_request(1'b0, make_addr(8'h12, 6'd3), 8'hFF, 64'h0, 0);
        add_request(1'b1, make_addr(8'h12, 6'd3), 8'h0F, 64'hAAAA_BBBB_CCCC_DDDD, 0);
        add_request(1'b0, make_addr(8'h12, 6'd3), 8'hFF, 64'h0, 0);
        add_request(1'b1, make_addr(8'h34, 6'd3), 8'hF0, 64'h1111_2222_3333_4444, 0);
        add_request(1'b0, make_addr(8'h34, 6'd3), 8'hFF, 64'h0, 0);
        add_request(1'b0, make_addr(8'h12, 6'd3), 8'hFF, 64'h0, 0);
        // Back-to-back burst with a slow consumer, enough to fill the queue.
        for (int i = 0; i < 8; i++)
        begin
            add_request(1'b1, make_addr(8'h40, 6'(8 + i)), 8'hFF,
                        {32'(i), 32'hC0DE_0000 + 32'(i)}, 4);
        end
        for (int i = 0; i < 8; i++)
        begin
            add_request(1'b0, make_addr(8'h40, 6'(8 + i)), 8'hFF, 64'h0, 2);
        end
        // Random traffic over a handful of sets and tags.
        for (int i = 0; i < 200; i++)
        begin
            add_request(1'($urandom_range(0, 1)),
                        make_addr(8'(8'h20 + $urandom_range(0, 2)), 6'($urandom_range(0, 3))),
                        8'($urandom()), {$urandom(), $urandom()}, int'($urandom_range(0, 3)));
        end
    endtask

    task automatic drive_requests();
        int                              waited;
        logic                            hit_v;
        logic [`CACHE_LINE_BITS - 1 : 0] rdata_v;
        for (int i = 0; i < tbl_addr.size(); i++)
        begin
            @(negedge clk_in);
            req_valid    = 1'b1;
            req_write    = tbl_write[i];
            req_addr.raw = tbl_addr[i];
            req_byte_en  = tbl_mask[i];
            req_wdata    = tbl_data[i];
            waited       = 0;
            while (!req_ready)
            begin
                ready_fell = 1'b1;
                @(negedge clk_in);
                waited++;
                if (waited > WAIT_LIMIT)
                begin
                    $display("The request port stayed busy past the timeout.");
                    fail_and_stop();
                end
            end
            // The request is taken at the coming rising edge.
            apply_model(tbl_write[i], tbl_addr[i], tbl_mask[i], tbl_data[i], hit_v, rdata_v);
            exp_write.push_back(tbl_write[i]);
            exp_hit.push_back(hit_v);
            exp_rdata.push_back(rdata_v);
            exp_stall.push_back(tbl_stall[i]);
        end
        @(negedge clk_in);
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int waited;
        int stall;
        for (int i = 0; i < tbl_addr.size(); i++)
        begin
            waited = 0;
            while (!rsp_valid)
            begin
                @(negedge clk_in);
                waited++;
                if (waited > WAIT_LIMIT)
                begin
                    $display("No response arrived before the timeout.");
                    fail_and_stop();
                end
            end
            if (exp_write.size() == 0)
            begin
                $display("A response arrived with no request pending.");
                fail_and_stop();
            end
            stall = exp_stall.pop_front();
            repeat (stall) @(negedge clk_in);
            check_value("rsp_valid", 64'(rsp_valid), 64'd1);
            check_value("rsp_write", 64'(rsp_write), 64'(exp_write.pop_front()));
            check_value("rsp_hit", 64'(rsp_hit), 64'(exp_hit.pop_front()));
            check_value("rsp_rdata", rsp_rdata, exp_rdata.pop_front());
            rsp_ready = 1'b1;
            @(negedge clk_in);
            rsp_ready = 1'b0;
        end
    endtask

    initial
    begin
        reset_in    = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_byte_en = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        ready_fell  = 1'b0;
        void'($urandom(6));
        for (int s = 0; s < `CACHE_NUM_SET; s++)
        begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
            model_line[s]  = '0;
        end
        build_table();
        repeat (16) @(negedge clk_in);
        reset_in = 1'b0;
        fork
            drive_requests();
            collect_responses();
        join
        // Nothing else may come out once every request is answered.
        repeat (20)
        begin
            @(negedge clk_in);
            if (rsp_valid)
            begin
                $display("An extra response appeared after the last request.");
                fail_and_stop();
            end
        end
        check_value("req_ready_fell", 64'(ready_fell), 64'd1);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+src
src/cache_pkg.sv
src/single_port_lutram.sv
src/request_queue.sv
src/cache_lookup.sv
src/cache_top.sv
tb/cache_checker.sv
tb/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench.

VERILATOR ?= verilator
TOP       ?= cache_tb
OBJ_DIR   ?= obj_dir
FILE_LIST ?= tb.f
FLAGS     ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The simulator exits non-zero when the run ends in $fatal.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
